// File: hw/trace_pkg.sv
// Shared definitions for the RVFI trace unit
// Widths, access masks, record layout, register map and RV32I opcodes
`default_nettype none

package trace_pkg;

  // Basic data widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  access_t;
  typedef logic [15:0] drop_t;

  // Accessed data items, one bit each
  localparam access_t ACC_RS1 = 4'b0001;
  localparam access_t ACC_RS2 = 4'b0010;
  localparam access_t ACC_RD  = 4'b0100;
  localparam access_t ACC_MEM = 4'b1000;

  // Instruction format classes
  typedef enum logic [3:0] {
    CLS_INVALID = 4'd0,
    CLS_R,
    CLS_I,
    CLS_SHIFT,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_U,
    CLS_CSR,
    CLS_SYSTEM,
    CLS_FENCE
  } insn_class_e;

  // Record queue
  localparam int RECORD_WORDS = 5;
  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

  // One extra bit so a full queue is representable
  typedef logic [FIFO_PTR_W:0] level_t;

  // Info word field positions with all other bits zero
  localparam int INFO_CLS_LSB = 0;
  localparam int INFO_ACC_LSB = 4;
  localparam int INFO_RD_LSB  = 8;
  localparam int INFO_RS1_LSB = 13;
  localparam int INFO_RS2_LSB = 18;

  // Wishbone word addresses
  localparam logic [2:0] REG_CTRL   = 3'd0;
  localparam logic [2:0] REG_STATUS = 3'd1;
  localparam logic [2:0] REG_POP    = 3'd2;
  localparam logic [2:0] REG_PC     = 3'd3;
  localparam logic [2:0] REG_INSN   = 3'd4;
  localparam logic [2:0] REG_CYCLE  = 3'd5;
  localparam logic [2:0] REG_INFO   = 3'd6;
  localparam logic [2:0] REG_OPND   = 3'd7;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

endpackage

`default_nettype wire

// File: hw/rvfi_classifier.sv
// RV32I instruction classifier
// Decodes one retired instruction into its format class, accessed
// items, register numbers and the operand a disassembler would show
`default_nettype none

module rvfi_classifier (
  input  trace_pkg::word_t       insn,
  input  trace_pkg::word_t       pc,
  output trace_pkg::insn_class_e insn_class,
  output trace_pkg::access_t     access,
  output trace_pkg::reg_addr_t   rd,
  output trace_pkg::reg_addr_t   rs1,
  output trace_pkg::reg_addr_t   rs2,
  output trace_pkg::word_t       operand
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  trace_pkg::word_t imm_i;
  trace_pkg::word_t imm_s;
  trace_pkg::word_t imm_b;
  trace_pkg::word_t imm_j;

  // Every major opcode ends in 2'b11, so compressed words fall to INVALID
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    insn_class = trace_pkg::CLS_INVALID;
    access     = '0;
    operand    = '0;

    case (opcode)
      trace_pkg::OPC_LUI, trace_pkg::OPC_AUIPC: begin
        insn_class = trace_pkg::CLS_U;
        access     = trace_pkg::ACC_RD;
        operand    = {12'b0, insn[31:12]};
      end
      trace_pkg::OPC_JAL: begin
        insn_class = trace_pkg::CLS_JAL;
        access     = trace_pkg::ACC_RD;
        operand    = pc + imm_j;
      end
      trace_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) begin
          insn_class = trace_pkg::CLS_JALR;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD;
          operand    = imm_i;
        end
      end
      trace_pkg::OPC_BRANCH: begin
        // funct3 010 and 011 are unassigned
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          insn_class = trace_pkg::CLS_BRANCH;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2;
          operand    = pc + imm_b;
        end
      end
      trace_pkg::OPC_OPIMM: begin
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          // SLLI and SRLI need funct7 0, SRAI needs 0x20
          if (funct7 == 7'h00 || (funct3 == 3'b101 && funct7 == 7'h20)) begin
            insn_class = trace_pkg::CLS_SHIFT;
            access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD;
            operand    = {27'b0, insn[24:20]};
          end
        end else begin
          insn_class = trace_pkg::CLS_I;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD;
          operand    = imm_i;
        end
      end
      trace_pkg::OPC_OP: begin
        // Base ops, SUB/SRA, and the M extension
        if (funct7 == 7'h00 || funct7 == 7'h01 ||
            (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          insn_class = trace_pkg::CLS_R;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2 | trace_pkg::ACC_RD;
        end
      end
      trace_pkg::OPC_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          insn_class = trace_pkg::CLS_LOAD;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD | trace_pkg::ACC_MEM;
          operand    = imm_i;
        end
      end
      trace_pkg::OPC_STORE: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          insn_class = trace_pkg::CLS_STORE;
          access     = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2 | trace_pkg::ACC_MEM;
          operand    = imm_s;
        end
      end
      trace_pkg::OPC_MISCMEM: begin
        if (funct3 == 3'b000) begin
          // Predecessor and successor sets
          insn_class = trace_pkg::CLS_FENCE;
          operand    = {24'b0, insn[27:20]};
        end else if (insn == 32'h0000_100f) begin
          insn_class = trace_pkg::CLS_FENCE;
        end
      end
      trace_pkg::OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (insn)
            32'h0000_0073,          // ECALL
            32'h0010_0073,          // EBREAK
            32'h3020_0073,          // MRET
            32'h7b20_0073,          // DRET
            32'h1050_0073: begin    // WFI
              insn_class = trace_pkg::CLS_SYSTEM;
            end
            default: ;
          endcase
        end else if (funct3 != 3'b100) begin
          // Immediate forms carry a zimm in the rs1 field
          insn_class = trace_pkg::CLS_CSR;
          access     = funct3[2] ? trace_pkg::ACC_RD : (trace_pkg::ACC_RD | trace_pkg::ACC_RS1);
          operand    = {20'b0, insn[31:20]};
        end
      end
      default: ;
    endcase
  end

  assign rd  = |(access & trace_pkg::ACC_RD)  ? insn[11:7]  : '0;
  assign rs1 = |(access & trace_pkg::ACC_RS1) ? insn[19:15] : '0;
  assign rs2 = |(access & trace_pkg::ACC_RS2) ? insn[24:20] : '0;

endmodule

`default_nettype wire

// File: hw/trace_capture.sv
// Trace capture stage
// Stamps each retirement with the cycle count, stages the record
// for one cycle and counts records lost to a full queue
`default_nettype none

module trace_capture (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rvfi_valid,
  input  trace_pkg::word_t rvfi_insn,
  input  trace_pkg::word_t rvfi_pc_rdata,
  input  logic             enable,
  input  logic             fifo_full,
  output logic             push,
  output trace_pkg::word_t rec_pc,
  output trace_pkg::word_t rec_insn,
  output trace_pkg::word_t rec_cycle,
  output trace_pkg::word_t rec_info,
  output trace_pkg::word_t rec_opnd,
  output trace_pkg::drop_t drop_count
);

  trace_pkg::word_t       cycle_q;
  logic                   staged_q;
  trace_pkg::insn_class_e cls;
  trace_pkg::access_t     acc;
  trace_pkg::reg_addr_t   rd;
  trace_pkg::reg_addr_t   rs1;
  trace_pkg::reg_addr_t   rs2;
  trace_pkg::word_t       opnd;
  trace_pkg::word_t       info;

  rvfi_classifier u_classifier (
    .insn       (rvfi_insn),
    .pc         (rvfi_pc_rdata),
    .insn_class (cls),
    .access     (acc),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .operand    (opnd)
  );

  // Pack the info word
  always_comb begin
    info = '0;
    info[trace_pkg::INFO_CLS_LSB +: $bits(cls)] = cls;
    info[trace_pkg::INFO_ACC_LSB +: $bits(acc)] = acc;
    info[trace_pkg::INFO_RD_LSB  +: $bits(rd)]  = rd;
    info[trace_pkg::INFO_RS1_LSB +: $bits(rs1)] = rs1;
    info[trace_pkg::INFO_RS2_LSB +: $bits(rs2)] = rs2;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q    <= '0;
      staged_q   <= 1'b0;
      drop_count <= '0;
    end else begin
      cycle_q  <= cycle_q + 1'b1;
      staged_q <= rvfi_valid & enable;
      // Saturate rather than wrap
      if (staged_q && fifo_full && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid && enable) begin
      rec_pc    <= rvfi_pc_rdata;
      rec_insn  <= rvfi_insn;
      rec_cycle <= cycle_q;
      rec_info  <= info;
      rec_opnd  <= opnd;
    end
  end

  assign push = staged_q & ~fifo_full;

endmodule

`default_nettype wire

// File: hw/trace_fifo.sv
// Trace record queue
// Circular buffer of five-word records with a fill level
`default_nettype none

module trace_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push,
  input  logic              pop,
  input  trace_pkg::word_t  wr_pc,
  input  trace_pkg::word_t  wr_insn,
  input  trace_pkg::word_t  wr_cycle,
  input  trace_pkg::word_t  wr_info,
  input  trace_pkg::word_t  wr_opnd,
  output trace_pkg::word_t  head_pc,
  output trace_pkg::word_t  head_insn,
  output trace_pkg::word_t  head_cycle,
  output trace_pkg::word_t  head_info,
  output trace_pkg::word_t  head_opnd,
  output trace_pkg::level_t level,
  output logic              full
);

  trace_pkg::word_t                 mem_q [trace_pkg::FIFO_DEPTH][trace_pkg::RECORD_WORDS];
  logic [trace_pkg::FIFO_PTR_W-1:0] wptr_q;
  logic [trace_pkg::FIFO_PTR_W-1:0] rptr_q;
  logic                             do_pop;

  assign full   = level == trace_pkg::level_t'(trace_pkg::FIFO_DEPTH);
  assign do_pop = pop && level != '0;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q][0] <= wr_pc;
      mem_q[wptr_q][1] <= wr_insn;
      mem_q[wptr_q][2] <= wr_cycle;
      mem_q[wptr_q][3] <= wr_info;
      mem_q[wptr_q][4] <= wr_opnd;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (push && !do_pop) begin
        level <= level + 1'b1;
      end else if (do_pop && !push) begin
        level <= level - 1'b1;
      end
    end
  end

  assign head_pc    = mem_q[rptr_q][0];
  assign head_insn  = mem_q[rptr_q][1];
  assign head_cycle = mem_q[rptr_q][2];
  assign head_info  = mem_q[rptr_q][3];
  assign head_opnd  = mem_q[rptr_q][4];

endmodule

`default_nettype wire

// File: hw/trace_wb_regs.sv
// Wishbone classic register block for the trace unit
// Control, status, pop strobe and the head record words
`default_nettype none

module trace_wb_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [2:0]        wb_adr,
  input  trace_pkg::word_t  wb_dat_w,
  input  trace_pkg::level_t level,
  input  trace_pkg::drop_t  drop_count,
  input  trace_pkg::word_t  head_pc,
  input  trace_pkg::word_t  head_insn,
  input  trace_pkg::word_t  head_cycle,
  input  trace_pkg::word_t  head_info,
  input  trace_pkg::word_t  head_opnd,
  output trace_pkg::word_t  wb_dat_r,
  output logic              wb_ack,
  output logic              enable,
  output logic              pop
);

  logic             req;
  logic             wr_done;
  trace_pkg::word_t rd_mux;

  assign req = wb_cyc & wb_stb;

  // Writes land on the edge that completes the access
  assign wr_done = req & wb_ack & wb_we;
  assign pop     = wr_done && wb_adr == trace_pkg::REG_POP;

  always_comb begin
    case (wb_adr)
      trace_pkg::REG_CTRL:   rd_mux = {31'b0, enable};
      trace_pkg::REG_STATUS: rd_mux = {drop_count, 16'(level)};
      trace_pkg::REG_POP:    rd_mux = '0;
      trace_pkg::REG_PC:     rd_mux = head_pc;
      trace_pkg::REG_INSN:   rd_mux = head_insn;
      trace_pkg::REG_CYCLE:  rd_mux = head_cycle;
      trace_pkg::REG_INFO:   rd_mux = head_info;
      trace_pkg::REG_OPND:   rd_mux = head_opnd;
      default:               rd_mux = '0;
    endcase
  end

  // Ack one cycle after the request, low again for a cycle after
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack <= 1'b0;
      enable <= 1'b1;
    end else begin
      wb_ack <= req & ~wb_ack;
      if (wr_done && wb_adr == trace_pkg::REG_CTRL) begin
        enable <= wb_dat_w[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && !wb_ack) begin
      wb_dat_r <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: hw/trace_top.sv
// RVFI trace unit top level
// Capture stage, record queue and Wishbone register block
`default_nettype none

module trace_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rvfi_valid,
  input  trace_pkg::word_t rvfi_insn,
  input  trace_pkg::word_t rvfi_pc_rdata,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [2:0]       wb_adr,
  input  trace_pkg::word_t wb_dat_w,
  output trace_pkg::word_t wb_dat_r,
  output logic             wb_ack
);

  logic              push;
  logic              pop;
  logic              enable;
  logic              full;
  trace_pkg::level_t level;
  trace_pkg::drop_t  drop_count;
  trace_pkg::word_t  rec_pc;
  trace_pkg::word_t  rec_insn;
  trace_pkg::word_t  rec_cycle;
  trace_pkg::word_t  rec_info;
  trace_pkg::word_t  rec_opnd;
  trace_pkg::word_t  head_pc;
  trace_pkg::word_t  head_insn;
  trace_pkg::word_t  head_cycle;
  trace_pkg::word_t  head_info;
  trace_pkg::word_t  head_opnd;

  trace_capture u_capture (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_insn     (rvfi_insn),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .enable        (enable),
    .fifo_full     (full),
    .push          (push),
    .rec_pc        (rec_pc),
    .rec_insn      (rec_insn),
    .rec_cycle     (rec_cycle),
    .rec_info      (rec_info),
    .rec_opnd      (rec_opnd),
    .drop_count    (drop_count)
  );

  trace_fifo u_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push       (push),
    .pop        (pop),
    .wr_pc      (rec_pc),
    .wr_insn    (rec_insn),
    .wr_cycle   (rec_cycle),
    .wr_info    (rec_info),
    .wr_opnd    (rec_opnd),
    .head_pc    (head_pc),
    .head_insn  (head_insn),
    .head_cycle (head_cycle),
    .head_info  (head_info),
    .head_opnd  (head_opnd),
    .level      (level),
    .full       (full)
  );

  trace_wb_regs u_wb_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .level      (level),
    .drop_count (drop_count),
    .head_pc    (head_pc),
    .head_insn  (head_insn),
    .head_cycle (head_cycle),
    .head_info  (head_info),
    .head_opnd  (head_opnd),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .enable     (enable),
    .pop        (pop)
  );

endmodule

`default_nettype wire

// File: bench/tb_trace_top.sv
// Testbench for the RVFI trace unit
// Retires directed and random instructions, reads the records back over
// Wishbone and checks them against a reference decode of each instruction
`default_nettype none

module tb_trace_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_DIRECTED     = 19;
  localparam int N_RANDOM       = 200;
  localparam int N_OVERFLOW     = trace_pkg::FIFO_DEPTH + 5;
  localparam int TOTAL_RETIRE   = N_DIRECTED + N_RANDOM + 5 + N_OVERFLOW;
  localparam int TIMEOUT_CYCLES = TOTAL_RETIRE * 40 + 2000;
  localparam int ACK_LIMIT      = 16;

  localparam trace_pkg::word_t DIRECTED [N_DIRECTED] = '{
    32'h002081b3,  // add x3, x1, x2
    32'hffc30293,  // addi x5, x6, -4
    32'h40345393,  // srai x7, x8, 3
    32'h01052483,  // lw x9, 16(x10)
    32'h01053483,  // load with funct3 011
    32'hfeb62c23,  // sw x11, -8(x12)
    32'hfeb63c23,  // store with funct3 011
    32'h00208863,  // beq x1, x2, +16
    32'h100000ef,  // jal x1, +0x100
    32'h00c280e7,  // jalr x1, 12(x5)
    32'h12345237,  // lui x4, 0x12345
    32'habcde317,  // auipc x6, 0xabcde
    32'h30019173,  // csrrw x2, mstatus, x3
    32'h3052e173,  // csrrsi x2, mtvec, 5
    32'h00000073,  // ecall
    32'h30200073,  // mret
    32'h0ff0000f,  // fence
    32'h0000100f,  // fence.i
    32'h00004501   // compressed c.li
  };

  logic             clk_i;
  logic             rst_ni;
  logic             rvfi_valid;
  trace_pkg::word_t rvfi_insn;
  trace_pkg::word_t rvfi_pc_rdata;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [2:0]       wb_adr;
  trace_pkg::word_t wb_dat_w;
  trace_pkg::word_t wb_dat_r;
  logic             wb_ack;

  trace_pkg::word_t edge_cnt;
  logic [31:0]      lfsr_state;
  logic [159:0]     exp_q [$];
  logic             stim_done;
  string            test_name;
  int               err_count;
  int               test_err_base;
  int               tests_run;
  int               tests_failed;

  trace_top dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid    (rvfi_valid),
    .rvfi_insn     (rvfi_insn),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack)
  );

  always #2 clk_i = ~clk_i;

  // Cycle stamp model that reads zero at the first edge out of reset
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt <= '0;
    end else begin
      edge_cnt <= edge_cnt + 32'd1;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] next_random(input int nbits);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < nbits; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  // Expected info and operand words for one retired instruction
  function automatic void predict_words(input trace_pkg::word_t insn,
                                        input trace_pkg::word_t pc,
                                        output trace_pkg::word_t info,
                                        output trace_pkg::word_t opnd);
    logic [2:0]             f3;
    logic [6:0]             f7;
    trace_pkg::insn_class_e cls;
    trace_pkg::access_t     acc;
    trace_pkg::word_t       i_imm;
    trace_pkg::word_t       s_imm;
    trace_pkg::word_t       b_imm;
    trace_pkg::word_t       j_imm;
    f3    = insn[14:12];
    f7    = insn[31:25];
    i_imm = {{20{insn[31]}}, insn[31:20]};
    s_imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    b_imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    j_imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    cls   = trace_pkg::CLS_INVALID;
    acc   = 4'b0000;
    opnd  = '0;
    // Access mask bits are rs1 1, rs2 2, rd 4 and mem 8
    case (insn[6:0])
      7'b0110011: begin
        if (f7 == 7'h00 || f7 == 7'h01 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          cls = trace_pkg::CLS_R;
          acc = 4'b0111;
        end
      end
      7'b0010011: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          if (f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
            cls  = trace_pkg::CLS_SHIFT;
            acc  = 4'b0101;
            opnd = {27'b0, insn[24:20]};
          end
        end else begin
          cls  = trace_pkg::CLS_I;
          acc  = 4'b0101;
          opnd = i_imm;
        end
      end
      7'b0000011: begin
        if (f3 != 3'd3 && f3 < 3'd6) begin
          cls  = trace_pkg::CLS_LOAD;
          acc  = 4'b1101;
          opnd = i_imm;
        end
      end
      7'b0100011: begin
        if (f3 < 3'd3) begin
          cls  = trace_pkg::CLS_STORE;
          acc  = 4'b1011;
          opnd = s_imm;
        end
      end
      7'b1100011: begin
        if (f3 != 3'd2 && f3 != 3'd3) begin
          cls  = trace_pkg::CLS_BRANCH;
          acc  = 4'b0011;
          opnd = pc + b_imm;
        end
      end
      7'b1101111: begin
        cls  = trace_pkg::CLS_JAL;
        acc  = 4'b0100;
        opnd = pc + j_imm;
      end
      7'b1100111: begin
        if (f3 == 3'd0) begin
          cls  = trace_pkg::CLS_JALR;
          acc  = 4'b0101;
          opnd = i_imm;
        end
      end
      7'b0110111, 7'b0010111: begin
        cls  = trace_pkg::CLS_U;
        acc  = 4'b0100;
        opnd = insn >> 12;
      end
      7'b1110011: begin
        if (f3 == 3'd0) begin
          if (insn inside {32'h00000073, 32'h00100073, 32'h30200073,
                           32'h7b200073, 32'h10500073}) begin
            cls = trace_pkg::CLS_SYSTEM;
          end
        end else if (f3 != 3'd4) begin
          cls  = trace_pkg::CLS_CSR;
          acc  = f3[2] ? 4'b0100 : 4'b0101;
          opnd = insn >> 20;
        end
      end
      7'b0001111: begin
        if (f3 == 3'd0) begin
          cls  = trace_pkg::CLS_FENCE;
          opnd = {24'b0, insn[27:20]};
        end else if (insn == 32'h0000100f) begin
          cls = trace_pkg::CLS_FENCE;
        end
      end
      default: ;
    endcase
    info = {9'b0, acc[1] ? insn[24:20] : 5'b0, acc[0] ? insn[19:15] : 5'b0,
            acc[2] ? insn[11:7] : 5'b0, acc, cls};
  endfunction

  task automatic check_word(input string what, input trace_pkg::word_t expected,
                            input trace_pkg::word_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      err_count++;
    end
  endtask

  // Single classic cycle started half a nanosecond after an edge
  task automatic bus_access(input logic we, input logic [2:0] adr,
                            input trace_pkg::word_t wdata, output trace_pkg::word_t rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    do begin
      @(posedge clk_i);
      #0.5;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      $display("No Wishbone acknowledge for address %0d in test %s", adr, test_name);
      err_count++;
    end
    rdata = wb_dat_r;
    @(posedge clk_i);
    #0.5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] adr, output trace_pkg::word_t rdata);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  task automatic write_reg(input logic [2:0] adr, input trace_pkg::word_t wdata);
    trace_pkg::word_t unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  // Valid stays high until idle() so back-to-back retirements are possible
  task automatic retire(input trace_pkg::word_t insn, input trace_pkg::word_t pc,
                        input logic keep);
    trace_pkg::word_t info;
    trace_pkg::word_t opnd;
    predict_words(insn, pc, info, opnd);
    rvfi_valid    = 1'b1;
    rvfi_insn     = insn;
    rvfi_pc_rdata = pc;
    if (keep) begin
      exp_q.push_back({pc, insn, edge_cnt, info, opnd});
    end
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic idle(input int n);
    rvfi_valid = 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      #0.5;
    end
  endtask

  // Pops records while the queue holds any and compares them in order
  task automatic drain_records();
    trace_pkg::word_t status;
    trace_pkg::word_t got [5];
    logic [159:0]     rec;
    while (!stim_done || exp_q.size() != 0) begin
      read_reg(trace_pkg::REG_STATUS, status);
      if (status[15:0] != 16'd0) begin
        read_reg(trace_pkg::REG_PC, got[0]);
        read_reg(trace_pkg::REG_INSN, got[1]);
        read_reg(trace_pkg::REG_CYCLE, got[2]);
        read_reg(trace_pkg::REG_INFO, got[3]);
        read_reg(trace_pkg::REG_OPND, got[4]);
        write_reg(trace_pkg::REG_POP, '0);
        if (exp_q.size() == 0) begin
          $display("Unexpected record with pc %h in test %s", got[0], test_name);
          err_count++;
        end else begin
          rec = exp_q.pop_front();
          check_word("pc", rec[159:128], got[0]);
          check_word("insn", rec[127:96], got[1]);
          check_word("cycle", rec[95:64], got[2]);
          check_word("info", rec[63:32], got[3]);
          check_word("operand", rec[31:0], got[4]);
        end
      end
    end
  endtask

  task automatic play_directed();
    int i;
    for (i = 0; i < N_DIRECTED; i++) begin
      retire(DIRECTED[i], 32'h8000_0000 + 32'(4 * i), 1'b1);
      idle(20);
    end
  endtask

  task automatic play_random();
    trace_pkg::word_t insn;
    trace_pkg::word_t pc;
    logic [3:0]       sel;
    int               n;
    for (n = 0; n < N_RANDOM; n++) begin
      sel  = 4'(next_random(4));
      insn = next_random(25) << 7;
      // Mostly real major opcodes and sometimes any low seven bits
      case (sel)
        4'd0:    insn[6:0] = trace_pkg::OPC_LUI;
        4'd1:    insn[6:0] = trace_pkg::OPC_AUIPC;
        4'd2:    insn[6:0] = trace_pkg::OPC_JAL;
        4'd3:    insn[6:0] = trace_pkg::OPC_JALR;
        4'd4:    insn[6:0] = trace_pkg::OPC_BRANCH;
        4'd5:    insn[6:0] = trace_pkg::OPC_LOAD;
        4'd6:    insn[6:0] = trace_pkg::OPC_STORE;
        4'd7:    insn[6:0] = trace_pkg::OPC_OPIMM;
        4'd8:    insn[6:0] = trace_pkg::OPC_OP;
        4'd9:    insn[6:0] = trace_pkg::OPC_MISCMEM;
        4'd10:   insn[6:0] = trace_pkg::OPC_SYSTEM;
        default: insn[6:0] = 7'(next_random(7));
      endcase
      pc = next_random(30) << 2;
      retire(insn, pc, 1'b1);
      // Gap stays above the time one record takes to drain
      idle(16 + int'(next_random(4)));
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    int errs;
    errs = err_count - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("Test %s finished with no errors", test_name);
    end else begin
      tests_failed++;
      $display("Test %s finished with %0d errors", test_name, errs);
    end
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, %0d records never checked",
             TIMEOUT_CYCLES, exp_q.size());
    $display("Something failed");
    $finish;
  end

  initial begin : main
    trace_pkg::word_t rdata;
    int               i;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    rvfi_valid    = 1'b0;
    rvfi_insn     = '0;
    rvfi_pc_rdata = '0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    lfsr_state    = 32'h7219d592;
    stim_done     = 1'b1;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (10) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;

    start_test("reset_values");
    read_reg(trace_pkg::REG_CTRL, rdata);
    check_word("ctrl", 32'd1, rdata);
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status", 32'd0, rdata);
    end_test();

    start_test("directed");
    stim_done = 1'b0;
    fork
      begin
        play_directed();
        stim_done = 1'b1;
      end
      drain_records();
    join
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status", 32'd0, rdata);
    end_test();

    start_test("random");
    stim_done = 1'b0;
    fork
      begin
        play_random();
        stim_done = 1'b1;
      end
      drain_records();
    join
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status", 32'd0, rdata);
    end_test();

    start_test("enable");
    write_reg(trace_pkg::REG_CTRL, 32'd0);
    read_reg(trace_pkg::REG_CTRL, rdata);
    check_word("ctrl", 32'd0, rdata);
    retire(DIRECTED[0], 32'h9000_0000, 1'b0);
    retire(DIRECTED[2], 32'h9000_0004, 1'b0);
    retire(DIRECTED[4], 32'h9000_0008, 1'b0);
    idle(4);
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status while disabled", 32'd0, rdata);
    write_reg(trace_pkg::REG_CTRL, 32'd1);
    retire(DIRECTED[1], 32'h9000_0010, 1'b1);
    retire(DIRECTED[3], 32'h9000_0014, 1'b1);
    idle(4);
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status after enable", 32'd2, rdata);
    drain_records();
    end_test();

    start_test("overflow");
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status before overflow", 32'd0, rdata);
    for (i = 0; i < N_OVERFLOW; i++) begin
      retire(DIRECTED[i], 32'ha000_0000 + 32'(4 * i), i < trace_pkg::FIFO_DEPTH);
    end
    idle(4);
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status when full",
               {16'(N_OVERFLOW - trace_pkg::FIFO_DEPTH), 16'(trace_pkg::FIFO_DEPTH)}, rdata);
    drain_records();
    read_reg(trace_pkg::REG_STATUS, rdata);
    check_word("status after drain", {16'(N_OVERFLOW - trace_pkg::FIFO_DEPTH), 16'd0}, rdata);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/trace_pkg.sv
hw/rvfi_classifier.sv
hw/trace_capture.sv
hw/trace_fifo.sv
hw/trace_wb_regs.sv
hw/trace_top.sv
bench/tb_trace_top.sv

// File: run.sh
#!/bin/sh
# Build the trace unit testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_trace_top -o tb_trace_top
./obj_dir/tb_trace_top | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
